/* bench/execCore_check.sv */
// ######################################################################
// Execute core checker
// Shadow register file and T bit, in-order writeback and T compare
// ######################################################################

`timescale 1ns/1ps
`include "exec_config.svh"

module execCore_check (
	input  logic                    clock,
	input  logic                    rstN,
	input  execPkg::uCmd            opCmd,
	input  execPkg::regId           regIdRs,
	input  execPkg::regId           regIdRt,
	input  execPkg::regId           regIdRn,
	input  logic [`EXEC_DATA_W-1:0] imm,
	input  logic                    braFlush,
	input  logic                    hold,
	input  logic                    wbEn,
	input  execPkg::regId           wbId,
	input  logic [`EXEC_DATA_W-1:0] wbVal,
	input  logic                    statusT,
	input  logic                    endRun,	// Stimulus finished and drained
	output logic                    idle,		// Nothing left to compare
	output logic                    doneChk,
	output int                      errCount
);

	import execPkg::*;

	logic [`EXEC_DATA_W-1:0] shadowRegs [32];
	logic                    shadowT;
	regId                    expId [$];	// Expected writebacks, oldest first
	logic [`EXEC_DATA_W-1:0] expVal [$];
	int                      tDue [$];	// Edge at which statusT is checked
	logic                    tExp [$];
	int                      cycleCnt;
	int                      wbSeen;
	int                      tSeen;

	// Expected result of one op, compare flag in bit 0
	function automatic logic [`EXEC_DATA_W-1:0] refResult(
		input uCmd                     cmd,
		input logic [`EXEC_DATA_W-1:0] a,
		input logic [`EXEC_DATA_W-1:0] b,
		input logic [`EXEC_DATA_W-1:0] immVal
	);
		case (cmd)
			ADD:     return a + b;
			SUB:     return a - b;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			MOVI:    return immVal;
			CMPEQ:   return {{(`EXEC_DATA_W-1){1'b0}}, a == b};
			CMPGT:   return {{(`EXEC_DATA_W-1){1'b0}}, a > b};	// Unsigned
			MUL:     return a * b;	// Low word only
			default: return '0;
		endcase
	endfunction

	always @(posedge clock) begin : watchPipe
		logic [`EXEC_DATA_W-1:0] res;
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				shadowRegs[i] = '0;	// RF clears on reset too
			shadowT = 1'b0;
			expId.delete();
			expVal.delete();
			tDue.delete();
			tExp.delete();
			cycleCnt = 0;
			wbSeen = 0;
			tSeen = 0;
			errCount = 0;
			doneChk = 1'b0;
		end else begin
			cycleCnt++;
			// CMP at edge c lands in statusT at c+1, seen here at c+2
			while (tDue.size() > 0 && tDue[0] == cycleCnt) begin
				if (statusT !== tExp[0]) begin
					$display("ERR statusT expected %h got %h", tExp[0], statusT);
					errCount++;
				end
				tSeen++;
				void'(tDue.pop_front());
				void'(tExp.pop_front());
			end
			if (wbEn) begin
				if (expId.size() == 0) begin
					$display("Writeback to register %0d with no op waiting for it", wbId);
					errCount++;
				end else begin
					if (wbId !== expId[0]) begin
						$display("ERR wbId expected %h got %h", expId[0], wbId);
						errCount++;
					end
					if (wbVal !== expVal[0]) begin
						$display("ERR wbVal expected %h got %h", expVal[0], wbVal);
						errCount++;
					end
					wbSeen++;
					void'(expId.pop_front());
					void'(expVal.pop_front());
				end
			end
			if (!hold) begin	// Op accepted at this edge
				res = refResult(opCmd, shadowRegs[regIdRs], shadowRegs[regIdRt], imm);
				if (!braFlush) begin
					if ((opCmd inside {ADD, SUB, AND, OR, XOR, MOVI, MUL}) &&
						(regIdRn != `EXEC_ZERO_REG)) begin
						shadowRegs[regIdRn] = res;
						expId.push_back(regIdRn);
						expVal.push_back(res);
					end
					if (opCmd inside {CMPEQ, CMPGT})
						shadowT = res[0];
				end
				if (opCmd inside {CMPEQ, CMPGT}) begin	// Flushed ones check T unchanged
					tDue.push_back(cycleCnt + 2);
					tExp.push_back(shadowT);
				end
			end
			if (endRun && !doneChk) begin
				if (statusT !== shadowT) begin
					$display("ERR statusT expected %h got %h", shadowT, statusT);
					errCount++;
				end
				if (expId.size() != 0 || tDue.size() != 0) begin
					$display("Run ended with %0d writebacks never seen", expId.size());
					errCount++;
				end
				$display("Checker: %0d errors, %0d writebacks and %0d T updates compared",
					errCount, wbSeen, tSeen);
				doneChk = 1'b1;
			end
			idle = (expId.size() == 0) && (tDue.size() == 0);
		end
	end

endmodule

/* bench/execCore_sva.sv */
// ######################################################################
// Execute core assertions
// Writeback, hold and multiplier launch rules, bound into the core
// ######################################################################

`timescale 1ns/1ps
`include "exec_config.svh"

module execCore_sva (
	input  logic          clock,
	input  logic          rstN,
	input  logic          hold,		// Issue-side hold
	input  logic          ex2Hold,	// EX2 part of it
	input  logic          wbEn,
	input  execPkg::regId wbId,
	input  logic          mulStart
);

	// R0 never gets a writeback
	wbNotZero: assert property (@(posedge clock) disable iff (!rstN)
		wbEn |-> (wbId != `EXEC_ZERO_REG))
		else $error("wbEn high with wbId zero");

	// Second reset cycle on, pipeline registers are NOP
	holdInReset: assert property (@(posedge clock) (!rstN && $past(!rstN)) |-> !hold)
		else $error("hold high during reset");

	// Launch only when free, then EX2 waits for the fresh product
	mulStartFree: assert property (@(posedge clock) disable iff (!rstN)
		mulStart |-> !hold ##1 ex2Hold)
		else $error("mulStart while hold is high or EX2 not waiting for the product");

	// WB register takes a bubble behind every EX2 hold cycle
	noWbInHold: assert property (@(posedge clock) disable iff (!rstN)
		ex2Hold |=> !wbEn)
		else $error("writeback after an EX2 hold cycle");

endmodule

/* bench/execCore_tb.sv */
// ######################################################################
// Execute core testbench
// Seeded random micro-ops with directed MUL, compare and flush cases
// ######################################################################

`timescale 1ns/1ps
`include "exec_config.svh"

module execCore_tb;

	import execPkg::*;

	localparam int numRand = 400;
	localparam int numOps  = 32 + 6 + numRand;	// Register init, directed, random

	logic                    clock;
	logic                    rstN;
	uCmd                     opCmd;
	regId                    regIdRs;
	regId                    regIdRt;
	regId                    regIdRn;
	logic [`EXEC_DATA_W-1:0] imm;
	logic                    braFlush;
	logic                    hold;
	logic                    wbEn;
	regId                    wbId;
	logic [`EXEC_DATA_W-1:0] wbVal;
	logic                    statusT;
	logic                    endRun;
	logic                    idle;
	logic                    doneChk;
	int                      errCount;
	integer                  seed;
	logic                    lastHold;	// hold as seen by the last rising edge

	execCore DUT (
		.clock(clock), .rstN(rstN), .opCmd(opCmd), .regIdRs(regIdRs), .regIdRt(regIdRt),
		.regIdRn(regIdRn), .imm(imm), .braFlush(braFlush), .hold(hold), .wbEn(wbEn),
		.wbId(wbId), .wbVal(wbVal), .statusT(statusT)
	);

	execCore_check uCheck (
		.clock(clock), .rstN(rstN), .opCmd(opCmd), .regIdRs(regIdRs), .regIdRt(regIdRt),
		.regIdRn(regIdRn), .imm(imm), .braFlush(braFlush), .hold(hold), .wbEn(wbEn),
		.wbId(wbId), .wbVal(wbVal), .statusT(statusT), .endRun(endRun), .idle(idle),
		.doneChk(doneChk), .errCount(errCount)
	);

	bind execCore execCore_sva uSva (
		.clock(clock), .rstN(rstN), .hold(hold), .ex2Hold(ex2Hold), .wbEn(wbEn),
		.wbId(wbId), .mulStart(mulStart)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;	// 8 ns
	end

	always @(posedge clock)
		lastHold <= hold;

	// Called on a falling edge, keeps the op until an edge with hold low
	task automatic issueOp(
		input uCmd                     cmd,
		input regId                    rs,
		input regId                    rt,
		input regId                    rn,
		input logic [`EXEC_DATA_W-1:0] immVal,
		input logic                    flush
	);
		opCmd    = cmd;
		regIdRs  = rs;
		regIdRt  = rt;
		regIdRn  = rn;
		imm      = immVal;
		braFlush = flush;
		do
			@(negedge clock);
		while (lastHold);
	endtask

	task automatic randomOp();
		logic [31:0] pick;
		regId        rs;
		regId        rt;
		regId        rn;
		pick = {$random(seed)} % 11;	// Any opcode, SLEEP included
		rs   = regId'({$random(seed)} % 16);
		rt   = regId'({$random(seed)} % 16);
		rn   = regId'({$random(seed)} % 8);	// Narrow range, many dependencies
		issueOp(uCmd'(pick[3:0]), rs, rt, rn, $random(seed), ({$random(seed)} % 8) == 0);
	endtask

	initial begin
		seed     = 18582;
		rstN     = 1'b0;
		opCmd    = NOP;
		regIdRs  = '0;
		regIdRt  = '0;
		regIdRn  = '0;
		imm      = '0;
		braFlush = 1'b0;
		endRun   = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		for (int r = 0; r < 32; r++)
			issueOp(MOVI, '0, '0, regId'(r), $random(seed), 1'b0);	// R0 write dropped
		issueOp(MUL, 5'd1, 5'd2, 5'd3, '0, 1'b0);
		issueOp(ADD, 5'd3, 5'd1, 5'd4, '0, 1'b0);	// Needs the product
		issueOp(CMPEQ, 5'd4, 5'd4, 5'd0, '0, 1'b0);	// T set
		issueOp(CMPGT, 5'd2, 5'd2, 5'd0, '0, 1'b0);	// T clear
		issueOp(CMPEQ, 5'd6, 5'd6, 5'd0, '0, 1'b1);	// Flushed, T stays clear
		issueOp(MOVI, 5'd0, 5'd0, 5'd5, 32'h5a5a_0f0f, 1'b1);
		repeat (numRand)
			randomOp();
		opCmd    = NOP;
		regIdRs  = '0;
		regIdRt  = '0;
		braFlush = 1'b0;
		while (!(idle && !hold))
			@(negedge clock);
		endRun = 1'b1;
		while (!doneChk)
			@(negedge clock);
		if (errCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Worst op is a SLEEP, a few spare cycles for reset and drain
	initial begin
		repeat (numOps * (`EXEC_SLEEP_CYC + 2) + 16) @(posedge clock);
		$display("Run timed out, the pipeline never drained");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* execCore.f */
+incdir+hw
hw/execPkg.sv
hw/regFile.sv
hw/mulUnit.sv
hw/exStage1.sv
hw/exStage2.sv
hw/execCore.sv
bench/execCore_sva.sv
bench/execCore_check.sv
bench/execCore_tb.sv

/* hw/exStage1.sv */
// ######################################################################
// EX1 stage
// Operand forwarding, ALU and compare, multiplier launch, EX1/EX2 reg
// ######################################################################

`timescale 1ns/1ps
`include "exec_config.svh"

module exStage1 (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    hold,	// From EX2, freezes EX1
	input  execPkg::uCmd            opCmd,
	input  execPkg::regId           regIdRs,
	input  execPkg::regId           regIdRt,
	input  execPkg::regId           regIdRn,
	input  logic [`EXEC_DATA_W-1:0] imm,
	input  logic                    braFlush,
	input  logic [`EXEC_DATA_W-1:0] rfValA,
	input  logic [`EXEC_DATA_W-1:0] rfValB,
	input  logic                    wbEn,
	input  execPkg::regId           wbId,
	input  logic [`EXEC_DATA_W-1:0] wbVal,
	output execPkg::uCmd            ex1Cmd,
	output execPkg::regId           ex1Id,
	output logic [`EXEC_DATA_W-1:0] ex1Val,
	output logic                    ex1Flag,
	output logic                    ex1Flush,
	output logic                    mulStart,
	output logic [`EXEC_DATA_W-1:0] mulOpA,
	output logic [`EXEC_DATA_W-1:0] mulOpB,
	output logic                    stallIss
);

	import execPkg::*;

	logic                    ex1Writes;	// EX2 will write ex1Val
	logic                    loadEn;
	logic [`EXEC_DATA_W-1:0] srcA;
	logic [`EXEC_DATA_W-1:0] srcB;
	logic [`EXEC_DATA_W-1:0] aluRes;
	logic                    cmpFlag;

	assign ex1Writes = (ex1Cmd inside {ADD, SUB, AND, OR, XOR, MOVI}) && !ex1Flush &&
		(ex1Id != `EXEC_ZERO_REG);

	// Youngest value wins
	function automatic logic [`EXEC_DATA_W-1:0] fwdSel(
		input regId                    id,
		input logic [`EXEC_DATA_W-1:0] rfVal
	);
		if (ex1Writes && (ex1Id == id))
			return ex1Val;
		else if (wbEn && (wbId == id))
			return wbVal;
		else
			return rfVal;
	endfunction

	assign srcA = fwdSel(regIdRs, rfValA);
	assign srcB = fwdSel(regIdRt, rfValB);

	// MUL result not ready until it leaves EX2
	assign stallIss = (ex1Cmd == MUL) && !ex1Flush && (ex1Id != `EXEC_ZERO_REG) &&
		((ex1Id == regIdRs) || (ex1Id == regIdRt));

	assign loadEn = !hold && !stallIss;

	// Launch on the edge that moves the MUL into EX1
	assign mulStart = loadEn && (opCmd == MUL);
	assign mulOpA   = srcA;
	assign mulOpB   = srcB;

	always_comb begin
		case (opCmd)
			ADD:     aluRes = srcA + srcB;
			SUB:     aluRes = srcA - srcB;
			AND:     aluRes = srcA & srcB;
			OR:      aluRes = srcA | srcB;
			XOR:     aluRes = srcA ^ srcB;
			MOVI:    aluRes = imm;
			default: aluRes = '0;	// CMP, MUL, SLEEP, NOP
		endcase
	end

	assign cmpFlag = (opCmd == CMPEQ) ? (srcA == srcB) : (srcA > srcB);	// Unsigned GT

	// Control part of the EX1/EX2 register
	always_ff @(posedge clock) begin
		if (!rstN) begin
			ex1Cmd   <= NOP;
			ex1Id    <= `EXEC_ZERO_REG;
			ex1Flush <= 1'b0;
		end else if (!hold) begin
			if (stallIss) begin
				ex1Cmd   <= NOP;	// Bubble behind the MUL
				ex1Id    <= `EXEC_ZERO_REG;
				ex1Flush <= 1'b0;
			end else begin
				ex1Cmd   <= opCmd;
				ex1Id    <= regIdRn;
				ex1Flush <= braFlush;
			end
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (loadEn) begin
			ex1Val  <= aluRes;
			ex1Flag <= cmpFlag;
		end
	end

endmodule

/* hw/exStage2.sv */
// ######################################################################
// EX2 stage
// Result select, T update, flush squash, multi-cycle hold, WB register
// ######################################################################

`timescale 1ns/1ps
`include "exec_config.svh"

module exStage2 (
	input  logic                    clock,
	input  logic                    rstN,
	input  execPkg::uCmd            ex1Cmd,
	input  execPkg::regId           ex1Id,
	input  logic [`EXEC_DATA_W-1:0] ex1Val,
	input  logic                    ex1Flag,
	input  logic                    ex1Flush,
	input  logic [`EXEC_DATA_W-1:0] mulProduct,
	input  logic                    mulDone,
	output logic                    hold,
	output logic                    wbEn,
	output execPkg::regId           wbId,
	output logic [`EXEC_DATA_W-1:0] wbVal,
	output logic                    statusT
);

	import execPkg::*;

	localparam int cntW = $clog2(`EXEC_SLEEP_CYC + 1);

	logic [cntW-1:0]         holdCnt;
	logic                    sleepHold;
	logic                    mulHold;
	logic                    opWrites;
	logic                    setT;
	regId                    resId;
	logic [`EXEC_DATA_W-1:0] resVal;

	// Flushed ops still hold, they only lose their effects
	assign sleepHold = (ex1Cmd == SLEEP) && (holdCnt < cntW'(`EXEC_SLEEP_CYC));
	assign mulHold   = (ex1Cmd == MUL) && !mulDone;
	assign hold      = sleepHold || mulHold;

	assign opWrites = ex1Cmd inside {ADD, SUB, AND, OR, XOR, MOVI, MUL};
	assign resId    = ex1Flush ? `EXEC_ZERO_REG : ex1Id;	// Squash to R0
	assign resVal   = (ex1Cmd == MUL) ? mulProduct : ex1Val;
	assign setT     = (ex1Cmd inside {CMPEQ, CMPGT}) && !ex1Flush;

	// Counts hold cycles of a SLEEP, clears when it retires
	always_ff @(posedge clock) begin
		if (!rstN)
			holdCnt <= '0;
		else if (sleepHold)
			holdCnt <= holdCnt + ((holdCnt != '1) ? 1'b1 : 1'b0);
		else
			holdCnt <= '0;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wbEn    <= 1'b0;
			wbId    <= `EXEC_ZERO_REG;
			statusT <= 1'b0;
		end else begin
			wbEn <= opWrites && !hold && (resId != `EXEC_ZERO_REG);	// Bubble while held
			wbId <= resId;
			if (setT)
				statusT <= ex1Flag;
		end
	end

	always_ff @(posedge clock) begin
		wbVal <= resVal;
	end

endmodule

/* hw/execCore.sv */
// ######################################################################
// Execute core top
// EX1 and EX2 stages around the register file and the multiplier
// ######################################################################

`timescale 1ns/1ps
`include "exec_config.svh"

module execCore (
	input  logic                    clock,
	input  logic                    rstN,
	input  execPkg::uCmd            opCmd,
	input  execPkg::regId           regIdRs,
	input  execPkg::regId           regIdRt,
	input  execPkg::regId           regIdRn,
	input  logic [`EXEC_DATA_W-1:0] imm,
	input  logic                    braFlush,
	output logic                    hold,	// Issue side waits
	output logic                    wbEn,
	output execPkg::regId           wbId,
	output logic [`EXEC_DATA_W-1:0] wbVal,
	output logic                    statusT
);

	import execPkg::*;

	logic [`EXEC_DATA_W-1:0] rfValA;
	logic [`EXEC_DATA_W-1:0] rfValB;
	uCmd                     ex1Cmd;
	regId                    ex1Id;
	logic [`EXEC_DATA_W-1:0] ex1Val;
	logic                    ex1Flag;
	logic                    ex1Flush;
	logic                    mulStart;
	logic [`EXEC_DATA_W-1:0] mulOpA;
	logic [`EXEC_DATA_W-1:0] mulOpB;
	logic [`EXEC_DATA_W-1:0] mulProduct;
	logic                    mulDone;
	logic                    stallIss;
	logic                    ex2Hold;

	assign hold = ex2Hold || stallIss;	// Dependent op behind a MUL also waits

	regFile uRegFile (
		.clock  (clock),
		.rstN   (rstN),
		.rdIdA  (regIdRs),
		.rdIdB  (regIdRt),
		.rdValA (rfValA),
		.rdValB (rfValB),
		.wrEn   (wbEn),
		.wrId   (wbId),
		.wrVal  (wbVal)
	);

	mulUnit uMulUnit (
		.clock   (clock),
		.rstN    (rstN),
		.start   (mulStart),
		.opA     (mulOpA),
		.opB     (mulOpB),
		.product (mulProduct),
		.done    (mulDone)
	);

	exStage1 uExStage1 (
		.clock    (clock),
		.rstN     (rstN),
		.hold     (ex2Hold),
		.opCmd    (opCmd),
		.regIdRs  (regIdRs),
		.regIdRt  (regIdRt),
		.regIdRn  (regIdRn),
		.imm      (imm),
		.braFlush (braFlush),
		.rfValA   (rfValA),
		.rfValB   (rfValB),
		.wbEn     (wbEn),
		.wbId     (wbId),
		.wbVal    (wbVal),
		.ex1Cmd   (ex1Cmd),
		.ex1Id    (ex1Id),
		.ex1Val   (ex1Val),
		.ex1Flag  (ex1Flag),
		.ex1Flush (ex1Flush),
		.mulStart (mulStart),
		.mulOpA   (mulOpA),
		.mulOpB   (mulOpB),
		.stallIss (stallIss)
	);

	exStage2 uExStage2 (
		.clock      (clock),
		.rstN       (rstN),
		.ex1Cmd     (ex1Cmd),
		.ex1Id      (ex1Id),
		.ex1Val     (ex1Val),
		.ex1Flag    (ex1Flag),
		.ex1Flush   (ex1Flush),
		.mulProduct (mulProduct),
		.mulDone    (mulDone),
		.hold       (ex2Hold),
		.wbEn       (wbEn),
		.wbId       (wbId),
		.wbVal      (wbVal),
		.statusT    (statusT)
	);

endmodule

/* hw/execPkg.sv */
// ######################################################################
// Execute pipeline types
// Opcode encoding shared by both stages and the register id type
// ######################################################################

package execPkg;

	// Micro-op opcodes as presented by the issue side
	typedef enum logic [3:0] {
		NOP   = 4'd0,
		ADD   = 4'd1,
		SUB   = 4'd2,
		AND   = 4'd3,
		OR    = 4'd4,
		XOR   = 4'd5,
		MOVI  = 4'd6,	// Rn = imm
		CMPEQ = 4'd7,	// T only
		CMPGT = 4'd8,	// T only, unsigned
		MUL   = 4'd9,	// Multi-cycle
		SLEEP = 4'd10	// Fixed hold
	} uCmd;

	typedef logic [4:0] regId;	// 32 GPRs

endpackage

/* hw/exec_config.svh */
// ######################################################################
// Execute pipeline configuration
// Widths and cycle counts for the EX1/EX2 pipeline
// ######################################################################

`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath width
`define EXEC_DATA_W 32

// Multiplier iterations, 8 bits of the multiplier per cycle
`define EXEC_MUL_CYC (`EXEC_DATA_W / 8)

// Hold cycles for SLEEP
`define EXEC_SLEEP_CYC 6

`define EXEC_ZERO_REG 5'd0	// Reads zero, writes dropped

`endif

/* hw/mulUnit.sv */
// ######################################################################
// Iterative multiplier
// Shift-add over 8 multiplier bits per cycle, low word of the product
// ######################################################################

`timescale 1ns/1ps
`include "exec_config.svh"

module mulUnit (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    start,	// Loads operands, restarts
	input  logic [`EXEC_DATA_W-1:0] opA,
	input  logic [`EXEC_DATA_W-1:0] opB,
	output logic [`EXEC_DATA_W-1:0] product,
	output logic                    done	// Held until next start
);

	localparam int cntW = $clog2(`EXEC_MUL_CYC + 1);

	logic [`EXEC_DATA_W-1:0] mcand;		// Shifts left 8 per step
	logic [`EXEC_DATA_W-1:0] mplier;	// Shifts right 8 per step
	logic [`EXEC_DATA_W-1:0] acc;
	logic [`EXEC_DATA_W-1:0] partProd;
	logic [cntW-1:0]         iterCnt;
	logic                    busy;

	// One byte of the multiplier per cycle, upper bits fall off
	assign partProd = mcand * {{(`EXEC_DATA_W-8){1'b0}}, mplier[7:0]};
	assign product  = acc;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			iterCnt <= '0;
		end else if (start) begin
			busy    <= 1'b1;
			done    <= 1'b0;
			iterCnt <= '0;
		end else if (busy) begin
			iterCnt <= iterCnt + 1'b1;
			if (iterCnt == cntW'(`EXEC_MUL_CYC - 1)) begin
				busy <= 1'b0;	// Last byte
				done <= 1'b1;
			end
		end
	end

	// Datapath
	always_ff @(posedge clock) begin
		if (start) begin
			acc    <= '0;
			mcand  <= opA;
			mplier <= opB;
		end else if (busy) begin
			acc    <= acc + partProd;
			mcand  <= mcand << 8;
			mplier <= mplier >> 8;
		end
	end

endmodule

/* hw/regFile.sv */
// ######################################################################
// Register file
// 32 GPRs with two async read ports and one sync write port
// ######################################################################

`timescale 1ns/1ps
`include "exec_config.svh"

module regFile (
	input  logic                    clock,
	input  logic                    rstN,
	input  execPkg::regId           rdIdA,	// Rs port
	input  execPkg::regId           rdIdB,	// Rt port
	output logic [`EXEC_DATA_W-1:0] rdValA,
	output logic [`EXEC_DATA_W-1:0] rdValB,
	input  logic                    wrEn,
	input  execPkg::regId           wrId,
	input  logic [`EXEC_DATA_W-1:0] wrVal
);

	logic [`EXEC_DATA_W-1:0] regs [32];

	// No bypass here, EX1 forwards from the writeback register
	assign rdValA = (rdIdA == `EXEC_ZERO_REG) ? '0 : regs[rdIdA];
	assign rdValB = (rdIdB == `EXEC_ZERO_REG) ? '0 : regs[rdIdB];

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && (wrId != `EXEC_ZERO_REG)) begin
			regs[wrId] <= wrVal;	// R0 writes dropped
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the execCore testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f execCore.f --top-module execCore_tb \
	-Mdir obj_dir -o execCore_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/execCore_sim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
